// File: sources.f
+incdir+hw
hw/delayLinePkg.sv
hw/wishboneIf.sv
hw/delayLineController.sv
hw/wbArbiter.sv
hw/sampleSram.sv
hw/stereoDelayTop.sv
sim/stereoDelay_checker.sv
sim/stereoDelayTb.sv

// File: run.sh
#!/bin/sh
# Compile the testbench and DUT with Verilator, run it, then judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module stereoDelayTb \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/VstereoDelayTb > sim.log 2>&1
cat sim.log

grep -q "All checks passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: sim/stereoDelayTb.sv
`default_nettype none
`timescale 1ns/1ns

`include "delayLine_defines.svh"

module stereoDelayTb;

    localparam int depth   = `DELAY_DEPTH_BYTES;
    localparam int timeout = 100; // Cycles any single wait may take

    logic                         clk;
    logic                         rst;
    logic [1:0]                   record;     // Index 0 is left, index 1 is right
    logic [1:0]                   search;
    logic [1:0]                   effect;
    logic [1:0][`SAMPLE_BITS-1:0] sampleIn;
    logic [1:0][`OFFSET_BITS-1:0] offset;
    logic [1:0]                   ready;
    logic [1:0]                   sampleValid;
    logic [1:0][`SAMPLE_BITS-1:0] sampleOut;

    logic [`SAMPLE_BITS-1:0] hist [2][depth]; // Reference history with one ring per channel
    int                      wrIdx [2];       // Next slot the model writes
    int                      invalidLeft [2]; // Records still owed after an effect change

    stereoDelayTop i_stereoDelayTop (
        .clk          (clk),
        .rst          (rst),
        .recordL      (record[0]),
        .searchL      (search[0]),
        .effectL      (effect[0]),
        .sampleInL    (sampleIn[0]),
        .offsetL      (offset[0]),
        .readyL       (ready[0]),
        .sampleValidL (sampleValid[0]),
        .sampleOutL   (sampleOut[0]),
        .recordR      (record[1]),
        .searchR      (search[1]),
        .effectR      (effect[1]),
        .sampleInR    (sampleIn[1]),
        .offsetR      (offset[1]),
        .readyR       (ready[1]),
        .sampleValidR (sampleValid[1]),
        .sampleOutR   (sampleOut[1])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expVal);
        if (got !== expVal) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, expVal);
            $display("Checks failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic failTimeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Checks failed");
        $fatal(1, "A wait loop ran out of cycles");
    endtask

    task automatic waitReady(input int ch);
        int cycles;
        cycles = 0;
        while (!ready[ch]) begin // Sampled 1 ns after the edge where it is stable
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout) begin
                failTimeout("ready");
            end
        end
    endtask

    task automatic modelRecord(input int ch, input logic [`SAMPLE_BITS-1:0] val);
        hist[ch][wrIdx[ch]] = val;
        wrIdx[ch] = (wrIdx[ch] + 1) % depth;
        if (invalidLeft[ch] > 0) begin
            invalidLeft[ch]--;
        end
    endtask

    // Newest sample sits one below the write slot, older ones further back around the ring
    function automatic logic [`SAMPLE_BITS-1:0] expectedSample(input int ch, input int off);
        if (invalidLeft[ch] > 0) begin
            return '0;
        end
        return hist[ch][(wrIdx[ch] - 1 - off + 2 * depth) % depth];
    endfunction

    task automatic recordSample(input int ch, input logic [`SAMPLE_BITS-1:0] val);
        waitReady(ch);
        record[ch]   = 1'b1;
        sampleIn[ch] = val;
        @(posedge clk); // Accepted on this edge because ready was high
        #1;
        record[ch] = 1'b0;
        modelRecord(ch, val);
    endtask

    task automatic searchCheck(input int ch, input int off);
        logic [`SAMPLE_BITS-1:0] expVal;
        int                      cycles;
        expVal = expectedSample(ch, off);
        waitReady(ch);
        search[ch] = 1'b1;
        offset[ch] = off[`OFFSET_BITS-1:0];
        @(posedge clk);
        #1;
        search[ch] = 1'b0;
        cycles     = 0;
        while (!sampleValid[ch]) begin // Hits are already valid here, misses need the bus
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout) begin
                failTimeout("sampleValid");
            end
        end
        checkValue(ch ? "sampleOutR" : "sampleOutL", sampleOut[ch], expVal);
    endtask

    task automatic resetDefaults();
        int ch;
        checkValue("ready", ready, 2'b11);
        checkValue("sampleValid", sampleValid, 2'b00);
        for (ch = 0; ch < 2; ch++) begin
            searchCheck(ch, 0);
            searchCheck(ch, 3);
            searchCheck(ch, 4095);
            searchCheck(ch, depth - 1);
        end
    endtask

    task automatic readBackHistory();
        int i;
        for (i = 0; i < 42; i++) begin // Two bytes stay in the packing register
            recordSample(0, 8'($urandom()));
        end
        for (i = 0; i < 42; i++) begin
            searchCheck(0, i);
        end
    endtask

    task automatic channelTraffic(input int ch);
        int i;
        for (i = 0; i < 24; i++) begin
            recordSample(ch, 8'($urandom()));
            if (i % 3 == 2) begin
                searchCheck(ch, $urandom_range(63));
            end
        end
    endtask

    task automatic separateChannels();
        fork // Both channels run in lockstep and collide at the arbiter
            channelTraffic(0);
            channelTraffic(1);
        join
    endtask

    task automatic effectInvalidates();
        int i;
        effect[1] = ~effect[1];
        @(posedge clk); // Edge detected here with no record in flight
        #1;
        invalidLeft[1] = depth;
        searchCheck(1, 0);
        searchCheck(1, 30);
        for (i = 0; i < depth - 1; i++) begin
            recordSample(1, 8'($urandom()));
        end
        searchCheck(1, 0); // One record short of a full lap
        searchCheck(1, 1000);
        recordSample(1, 8'($urandom()));
        searchCheck(1, 0);
        searchCheck(1, 1);
        searchCheck(1, 5);
        searchCheck(1, 4000);
        searchCheck(1, depth - 1);
    endtask

    task automatic backPressureHold();
        int                      cycle;
        int                      accepted;
        int                      falls;
        int                      stores;
        int                      i;
        logic                    readyNow;
        logic [`SAMPLE_BITS-1:0] val;
        accepted  = 0;
        falls     = 0;
        stores    = 0;
        record[0] = 1'b1; // Held high the whole time
        for (cycle = 0; cycle < 40; cycle++) begin
            val          = 8'($urandom());
            sampleIn[0]  = val;
            readyNow     = ready[0];
            if (readyNow) begin
                if (wrIdx[0] % 4 == 3) begin
                    stores++; // Fourth byte of a word goes out on the bus
                end
                modelRecord(0, val);
                accepted++;
            end
            @(posedge clk);
            #1;
            if (readyNow && !ready[0]) begin
                falls++;
            end
        end
        record[0] = 1'b0;
        checkValue("readyFalls", falls, stores);
        for (i = 0; i < accepted + 4; i++) begin // Reaches past the held run into older history
            searchCheck(0, i);
        end
    endtask

    initial begin
        void'($urandom(75461));
        rst        = 1'b1;
        record     = '0;
        search     = '0;
        effect     = '0;
        sampleIn   = '0;
        offset     = '0;
        for (int ch = 0; ch < 2; ch++) begin
            wrIdx[ch]       = 0;
            invalidLeft[ch] = 0;
            for (int i = 0; i < depth; i++) begin
                hist[ch][i] = '0; // SRAM clears to silence at reset
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        resetDefaults();
        readBackHistory();
        separateChannels();
        effectInvalidates();
        backPressureHold();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/stereoDelay_checker.sv
`default_nettype none
`timescale 1ns/1ns

`include "delayLine_defines.svh"

module stereoDelayChecker (
    input logic                       clk,
    input logic                       rst,
    input logic                       cyc,         // Shared SRAM bus after the arbiter
    input logic                       stb,
    input logic                       we,
    input logic [`SRAM_ADDR_BITS-1:0] adr,
    input logic [`WORD_BITS-1:0]      datW,
    input logic                       ack,
    input logic [1:0]                 ready,       // Bit 0 is the left channel
    input logic [1:0]                 sampleValid
);

    // A strobe is only legal inside a bus cycle
    stbInCyc: assert property (@(posedge clk) disable iff (rst) stb |-> cyc)
        else $error("Shared bus raised stb without cyc");

    // The master holds the whole request until the slave answers
    reqStable: assert property (@(posedge clk) disable iff (rst)
        (stb && !ack) |=> (stb && $stable({we, adr, datW})))
        else $error("Shared bus request changed before ack");

    ackPulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("Shared bus ack lasted more than one cycle");

    validWhileReady: assert property (@(posedge clk) disable iff (rst)
        !(|(sampleValid & ~ready)))
        else $error("sampleValid was high while ready was low");

endmodule

bind stereoDelayTop stereoDelayChecker i_checker (
    .clk         (clk),
    .rst         (rst),
    .cyc         (busS.cyc),
    .stb         (busS.stb),
    .we          (busS.we),
    .adr         (busS.adr),
    .datW        (busS.datW),
    .ack         (busS.ack),
    .ready       ({readyR, readyL}),
    .sampleValid ({sampleValidR, sampleValidL})
);

`default_nettype wire

// File: hw/stereoDelayTop.sv
`default_nettype none
`timescale 1ns/1ns

`include "delayLine_defines.svh"

module stereoDelayTop (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    recordL,
    input  logic                    searchL,
    input  logic                    effectL,
    input  logic [`SAMPLE_BITS-1:0] sampleInL,
    input  logic [`OFFSET_BITS-1:0] offsetL,
    output logic                    readyL,
    output logic                    sampleValidL,
    output logic [`SAMPLE_BITS-1:0] sampleOutL,
    input  logic                    recordR,
    input  logic                    searchR,
    input  logic                    effectR,
    input  logic [`SAMPLE_BITS-1:0] sampleInR,
    input  logic [`OFFSET_BITS-1:0] offsetR,
    output logic                    readyR,
    output logic                    sampleValidR,
    output logic [`SAMPLE_BITS-1:0] sampleOutR
);

    wishboneIf busL ();  // Left controller to arbiter
    wishboneIf busR ();  // Right controller to arbiter
    wishboneIf busS ();  // Arbiter to the shared SRAM

    delayLineController #(.chanBase(1'b0)) i_ctrlL ( // Lower half of the SRAM
        .clk         (clk),
        .rst         (rst),
        .record      (recordL),
        .search      (searchL),
        .effect      (effectL),
        .sampleIn    (sampleInL),
        .offset      (offsetL),
        .ready       (readyL),
        .sampleValid (sampleValidL),
        .sampleOut   (sampleOutL),
        .bus         (busL.master)
    );

    delayLineController #(.chanBase(1'b1)) i_ctrlR ( // Upper half of the SRAM
        .clk         (clk),
        .rst         (rst),
        .record      (recordR),
        .search      (searchR),
        .effect      (effectR),
        .sampleIn    (sampleInR),
        .offset      (offsetR),
        .ready       (readyR),
        .sampleValid (sampleValidR),
        .sampleOut   (sampleOutR),
        .bus         (busR.master)
    );

    wbArbiter i_arbiter (
        .clk (clk),
        .rst (rst),
        .m0  (busL.slave),
        .m1  (busR.slave),
        .s   (busS.master)
    );

    sampleSram i_sram (
        .clk (clk),
        .rst (rst),
        .bus (busS.slave)
    );

endmodule

`default_nettype wire

// File: hw/sampleSram.sv
`default_nettype none
`timescale 1ns/1ns

`include "delayLine_defines.svh"

module sampleSram
    import delayLinePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    wishboneIf.slave bus
);

    localparam int depth      = 1 << `SRAM_ADDR_BITS;
    localparam int waitStates = `SRAM_WAIT_STATES;

    sramState              state;
    logic [3:0]            waitCnt; // Strobe cycles seen so far
    logic                  access;  // Read or write happens on this edge
    logic [`WORD_BITS-1:0] mem [0:depth-1];

    // Access fires once the strobe has been held for the full wait count
    assign access = ((state == sramIdle) && bus.cyc && bus.stb && (waitStates == 0)) ||
                    ((state == sramCount) && (waitCnt == waitStates[3:0]));
    assign bus.ack = (state == sramAck);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= sramIdle;
            waitCnt <= '0;
        end else begin
            case (state)
                sramIdle: begin
                    if (access) begin
                        state <= sramAck;
                    end else if (bus.cyc && bus.stb) begin
                        state   <= sramCount;
                        waitCnt <= 4'd1; // The first strobe cycle counts
                    end
                end
                sramCount: begin
                    if (access) begin
                        state <= sramAck;
                    end else if (!(bus.cyc && bus.stb)) begin
                        state <= sramIdle; // Master gave up the request
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                default: state <= sramIdle; // Ack lasts exactly one cycle
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0; // Empty history reads back as silence
            end
        end else if (access && bus.we) begin
            mem[bus.adr] <= bus.datW;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.datR <= mem[bus.adr]; // Held through the ack cycle
        end
    end

endmodule

`default_nettype wire

// File: hw/wbArbiter.sv
`default_nettype none
`timescale 1ns/1ns

module wbArbiter
    import delayLinePkg::*;
(
    input  logic      clk,
    input  logic      rst,
    wishboneIf.slave  m0,
    wishboneIf.slave  m1,
    wishboneIf.master s
);

    arbState state;
    logic    prioM1; // Master 1 wins the next tie

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= arbIdle;
            prioM1 <= 1'b0;
        end else begin
            case (state)
                arbIdle: begin
                    if (m0.cyc && (!prioM1 || !m1.cyc)) begin
                        state  <= arbM0;
                        prioM1 <= 1'b1; // Other side goes first next time
                    end else if (m1.cyc) begin
                        state  <= arbM1;
                        prioM1 <= 1'b0;
                    end
                end
                arbM0: if (s.ack) state <= arbIdle; // Released the cycle after ack
                arbM1: if (s.ack) state <= arbIdle;
                default: state <= arbIdle;
            endcase
        end
    end

    always_comb begin
        s.cyc  = 1'b0; // Slave sees nothing while no one owns the bus
        s.stb  = 1'b0;
        s.we   = 1'b0;
        s.adr  = '0;
        s.datW = '0;
        if (state == arbM0) begin
            s.cyc  = m0.cyc;
            s.stb  = m0.stb;
            s.we   = m0.we;
            s.adr  = m0.adr;
            s.datW = m0.datW;
        end else if (state == arbM1) begin
            s.cyc  = m1.cyc;
            s.stb  = m1.stb;
            s.we   = m1.we;
            s.adr  = m1.adr;
            s.datW = m1.datW;
        end
    end

    assign m0.ack  = (state == arbM0) && s.ack; // Losing master never sees an ack
    assign m1.ack  = (state == arbM1) && s.ack;
    assign m0.datR = (state == arbM0) ? s.datR : '0;
    assign m1.datR = (state == arbM1) ? s.datR : '0;

endmodule

`default_nettype wire

// File: hw/delayLineController.sv
`default_nettype none
`timescale 1ns/1ns

`include "delayLine_defines.svh"

module delayLineController
    import delayLinePkg::*;
#(
    parameter bit chanBase = 1'b0 // Top SRAM address bit owned by this channel
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    record,      // Store sampleIn as the newest sample
    input  logic                    search,      // Look up the sample offset samples back
    input  logic                    effect,      // Any edge throws the history away
    input  logic [`SAMPLE_BITS-1:0] sampleIn,
    input  logic [`OFFSET_BITS-1:0] offset,      // Zero is the newest sample
    output logic                    ready,
    output logic                    sampleValid,
    output logic [`SAMPLE_BITS-1:0] sampleOut,
    wishboneIf.master               bus
);

    ctrlState                   state;
    logic [`OFFSET_BITS-1:0]    wrPtr;      // Byte index of the next sample to record
    logic [`OFFSET_BITS-1:0]    wrPtrNext;
    logic [`OFFSET_BITS-1:0]    validPtr;   // Pointer at which the history is full again
    logic [`OFFSET_BITS-1:0]    srchIdx;    // Byte index being searched for
    logic [`WORD_BITS-1:0]      packReg;    // Word being filled one sample at a time
    logic [`WORD_BITS-1:0]      packNext;
    logic [`WORD_BITS-1:0]      cacheWord;  // Last word read from the SRAM
    logic [`CHAN_WORD_BITS-1:0] cacheAdr;
    logic                       cacheValid;
    logic                       histValid;  // Low while old-effect samples may still be read
    logic                       effectQ;
    logic                       effectEdge;
    logic                       acceptRec;
    logic                       acceptSrch;
    logic                       packHit;
    logic                       cacheHit;
    logic                       busDone;
    logic [1:0]                 byteSel;    // Byte lane to return once a fetch completes
    logic [`SRAM_ADDR_BITS-1:0] busAdr;
    logic [`WORD_BITS-1:0]      busDat;
    logic                       busWe;

    assign ready      = (state == ctrlIdle); // Busy for the whole bus access
    assign acceptRec  = ready && record;
    assign acceptSrch = ready && search && !record; // Record wins a tie
    assign effectEdge = (effect != effectQ);
    assign busDone    = (state != ctrlIdle) && bus.ack;
    assign wrPtrNext  = acceptRec ? wrPtr + 1'b1 : wrPtr;
    assign srchIdx    = wrPtr - 1'b1 - offset; // Wraps around the circular buffer

    // Only bytes below the write lane of the open word are new, the rest still sit in SRAM
    assign packHit  = (srchIdx[`OFFSET_BITS-1:2] == wrPtr[`OFFSET_BITS-1:2]) &&
                      (srchIdx[1:0] < wrPtr[1:0]);
    assign cacheHit = cacheValid && (srchIdx[`OFFSET_BITS-1:2] == cacheAdr);

    always_comb begin
        packNext = packReg;
        packNext[wrPtr[1:0]*`SAMPLE_BITS +: `SAMPLE_BITS] = sampleIn; // Drop into its lane
    end

    assign bus.cyc  = (state != ctrlIdle);
    assign bus.stb  = (state != ctrlIdle); // Request held until ack in every bus state
    assign bus.we   = busWe;
    assign bus.adr  = busAdr;
    assign bus.datW = busDat;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ctrlIdle;
            wrPtr       <= '0;
            validPtr    <= '0;
            histValid   <= 1'b1; // Empty history is valid and reads zero
            cacheValid  <= 1'b0;
            sampleValid <= 1'b0;
            effectQ     <= 1'b0;
            busWe       <= 1'b0;
        end else begin
            effectQ     <= effect;
            wrPtr       <= wrPtrNext;
            sampleValid <= 1'b0; // Pulse lasts a single cycle
            if (effectEdge) begin
                histValid <= 1'b0;
                validPtr  <= wrPtrNext; // A full lap of records brings the pointer back here
            end else if (!histValid && acceptRec && (wrPtrNext == validPtr)) begin
                histValid <= 1'b1;
            end
            case (state)
                ctrlIdle: begin
                    if (acceptRec) begin
                        if (wrPtr[1:0] == 2'd3) begin // Fourth sample completes the word
                            state <= ctrlStore;
                            busWe <= 1'b1;
                            if (cacheAdr == wrPtr[`OFFSET_BITS-1:2]) begin
                                cacheValid <= 1'b0; // Cached copy is about to go stale
                            end
                        end
                    end else if (acceptSrch) begin
                        if (!histValid || packHit || cacheHit) begin
                            sampleValid <= 1'b1; // Answered without the bus
                        end else begin
                            state <= ctrlFetch;
                            busWe <= 1'b0;
                        end
                    end
                end
                default: begin // Fetch, store and the ack wait all hold the bus
                    if (busDone) begin
                        state <= ctrlIdle;
                        if (!busWe) begin
                            cacheValid  <= 1'b1;
                            sampleValid <= 1'b1;
                        end
                    end else begin
                        state <= ctrlWaitAck;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (acceptRec) begin
            packReg <= packNext;
            if (wrPtr[1:0] == 2'd3) begin
                busAdr <= {chanBase, wrPtr[`OFFSET_BITS-1:2]};
                busDat <= packNext; // Includes the sample accepted this cycle
            end
        end else if (acceptSrch) begin
            byteSel <= srchIdx[1:0];
            busAdr  <= {chanBase, srchIdx[`OFFSET_BITS-1:2]};
            if (!histValid) begin
                sampleOut <= '0;
            end else if (packHit) begin
                sampleOut <= packReg[srchIdx[1:0]*`SAMPLE_BITS +: `SAMPLE_BITS];
            end else if (cacheHit) begin
                sampleOut <= cacheWord[srchIdx[1:0]*`SAMPLE_BITS +: `SAMPLE_BITS];
            end
        end
        if (busDone && !busWe) begin
            cacheWord <= bus.datR; // Refill so nearby searches skip the bus
            cacheAdr  <= busAdr[`CHAN_WORD_BITS-1:0];
            sampleOut <= bus.datR[byteSel*`SAMPLE_BITS +: `SAMPLE_BITS];
        end
    end

endmodule

`default_nettype wire

// File: hw/wishboneIf.sv
`default_nettype none
`timescale 1ns/1ns

`include "delayLine_defines.svh"

interface wishboneIf;

    logic                       cyc;  // Bus cycle in progress
    logic                       stb;  // Valid request on the bus
    logic                       we;   // High for a write, low for a read
    logic [`SRAM_ADDR_BITS-1:0] adr;  // Word address
    logic [`WORD_BITS-1:0]      datW; // Write data from the master
    logic [`WORD_BITS-1:0]      datR; // Read data, valid while ack is high
    logic                       ack;  // One-cycle completion from the slave

    modport master (
        output cyc, stb, we, adr, datW,
        input  datR, ack
    );

    modport slave (
        input  cyc, stb, we, adr, datW,
        output datR, ack
    );

endinterface

`default_nettype wire

// File: hw/delayLinePkg.sv
`default_nettype none

package delayLinePkg;

    typedef enum logic [1:0] {
        ctrlIdle,    // Ready for a record or a search
        ctrlFetch,   // First cycle of a bus read after a cache miss
        ctrlStore,   // First cycle of a bus write of a full packed word
        ctrlWaitAck  // Request held on the bus until the slave acks
    } ctrlState;

    typedef enum logic [1:0] {
        arbIdle,  // No master owns the bus
        arbM0,    // Master 0 is routed to the slave
        arbM1     // Master 1 is routed to the slave
    } arbState;

    typedef enum logic [1:0] {
        sramIdle,   // Waiting for a strobe
        sramCount,  // Burning wait states
        sramAck     // Access done, ack is high for this cycle
    } sramState;

endpackage

`default_nettype wire

// File: hw/delayLine_defines.svh
`ifndef DELAY_LINE_DEFINES_SVH
`define DELAY_LINE_DEFINES_SVH

// Depth of one channel's history in samples, a whole power of two
`define DELAY_DEPTH_BYTES 8192

// Word address width inside one channel, four samples per word
`define CHAN_WORD_BITS 11

// Full SRAM word address, the extra top bit picks the channel
`define SRAM_ADDR_BITS 12

// Offset into the past, wide enough to reach the oldest sample
`define OFFSET_BITS 13

// Cycles the SRAM stalls a strobe before it acknowledges
`define SRAM_WAIT_STATES 2

`define SAMPLE_BITS 8 // One audio sample
`define WORD_BITS 32  // Four packed samples

`endif
